//--- Bender.yml
package:
  name: mini_core

sources:
  - include_dirs:
      - include
    files:
      - design/isaPkg.sv
      - design/busPkg.sv
      - design/controlUnit.sv
      - design/fetchUnit.sv
      - design/executeUnit.sv
      - design/memArbiter.sv
      - design/unifiedMem.sv
      - design/miniCore.sv
  - target: simulation
    files:
      - bench/miniCore_properties.sv
      - bench/miniCoreTb.sv

//--- bench/miniCoreTb.sv
`timescale 1ns/1ps

module miniCoreTb;

    import isaPkg::*;
    import busPkg::*;

    localparam int NUM_TESTS = 4;
    localparam int MAX_WORDS = 48;
    localparam int MAX_RET   = 32;

    logic           clk = 1'b0;
    logic           rstN;
    logic           run;
    logic           hostWr;
    memAddrT        hostAddr;
    wordT           hostData;
    logic           retireValid;
    retireT         retire;

    // Programs and expected retire traces
    wordT   prog    [NUM_TESTS][MAX_WORDS];
    int     nWords  [NUM_TESTS];
    pcT     expPc   [NUM_TESTS][MAX_RET];
    regIdxT expRd   [NUM_TESTS][MAX_RET];
    wordT   expData [NUM_TESTS][MAX_RET];
    int     nRet    [NUM_TESTS];

    miniCore dut (
        .clk         (clk),
        .rstN        (rstN),
        .run         (run),
        .hostWr      (hostWr),
        .hostAddr    (hostAddr),
        .hostData    (hostData),
        .retireValid (retireValid),
        .retire      (retire)
    );

    always #50 clk = ~clk;

    function automatic instrT encR(logic [6:0] f7, regIdxT rs2, regIdxT rs1,
                                   logic [2:0] f3, regIdxT rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic instrT encI(opcodeT op, logic [11:0] imm, regIdxT rs1,
                                   logic [2:0] f3, regIdxT rd);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instrT encS(logic [11:0] imm, regIdxT rs2, regIdxT rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic instrT encB(logic [2:0] f3, regIdxT rs1, regIdxT rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
    endfunction

    function automatic instrT encU(opcodeT op, logic [19:0] imm, regIdxT rd);
        return {imm, rd, op};
    endfunction

    function automatic instrT encJ(regIdxT rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
    endfunction

    task automatic emit(int t, instrT w);
        prog[t][nWords[t]] = w;
        nWords[t]++;
    endtask

    // Word that retires at its own pc
    task automatic emitRet(int t, instrT w, regIdxT rd, wordT d);
        expPc[t][nRet[t]]   = pcT'(4 * nWords[t]);
        expRd[t][nRet[t]]   = rd;
        expData[t][nRet[t]] = d;
        nRet[t]++;
        emit(t, w);
    endtask

    task automatic failNow();
        $display("test failed");
        $fatal(1, "stopping after first mismatch");
    endtask

    task automatic checkWord(string name, wordT exp, wordT act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            failNow();
        end
    endtask

    task automatic checkReg(string name, regIdxT exp, regIdxT act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            failNow();
        end
    endtask

    task automatic checkPc(string name, pcT exp, pcT act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            failNow();
        end
    endtask

    task automatic buildTable();
        logic [11:0] iA;
        logic [11:0] iB;
        logic [19:0] iU;
        logic [19:0] iU2;
        wordT        a;
        wordT        b;
        wordT        ib;
        wordT        dA;
        wordT        dB;
        int          f3s [6]  = '{0, 1, 4, 5, 6, 7};
        int          tkA [6]  = '{1, 1, 1, 2, 2, 1};
        int          tkB [6]  = '{1, 2, 2, 1, 1, 2};
        int          ntA [6]  = '{1, 1, 2, 1, 1, 2};
        int          ntB [6]  = '{2, 1, 1, 2, 2, 1};
        iA = 12'($urandom);
        iB = 12'($urandom);
        iU = 20'($urandom);
        iU2 = 20'($urandom);
        dA = 32'h9e37_79b9;
        dB = 32'h7f4a_7c15;
        a  = {{20{iA[11]}}, iA};
        ib = {{20{iB[11]}}, iB};
        b  = -32'sd5;
        // ALU, R-type then I-type
        emitRet(0, encI(OP_IMM, iA, 0, 0, 1), 1, a);
        emitRet(0, encI(OP_IMM, 12'hffb, 0, 0, 2), 2, b);
        emitRet(0, encR(0, 2, 1, 0, 3), 3, a + b);
        emitRet(0, encR(7'h20, 2, 1, 0, 4), 4, a - b);
        emitRet(0, encR(0, 2, 1, 7, 5), 5, a & b);
        emitRet(0, encR(0, 2, 1, 6, 6), 6, a | b);
        emitRet(0, encR(0, 2, 1, 4, 7), 7, a ^ b);
        emitRet(0, encR(0, 2, 1, 1, 8), 8, a << b[4:0]);
        emitRet(0, encR(0, 1, 2, 5, 9), 9, b >> a[4:0]);
        emitRet(0, encR(7'h20, 1, 2, 5, 10), 10, wordT'($signed(b) >>> a[4:0]));
        emitRet(0, encR(0, 1, 2, 2, 11), 11, wordT'($signed(b) < $signed(a)));
        emitRet(0, encR(0, 1, 2, 3, 12), 12, wordT'(b < a));
        emitRet(0, encI(OP_IMM, iB, 2, 2, 13), 13, wordT'($signed(b) < $signed(ib)));
        emitRet(0, encI(OP_IMM, iB, 2, 3, 14), 14, wordT'(b < ib));
        emitRet(0, encI(OP_IMM, iB, 1, 4, 15), 15, a ^ ib);
        emitRet(0, encI(OP_IMM, iB, 1, 6, 16), 16, a | ib);
        emitRet(0, encI(OP_IMM, iB, 1, 7, 17), 17, a & ib);
        emitRet(0, encI(OP_IMM, 12'h003, 1, 1, 18), 18, a << 3);
        emitRet(0, encI(OP_IMM, 12'h004, 2, 5, 19), 19, b >> 4);
        emitRet(0, encI(OP_IMM, 12'h402, 2, 5, 20), 20, wordT'($signed(b) >>> 2));
        emitRet(0, encI(OP_IMM, 12'h007, 1, 0, 0), 0, a + 7);
        emitRet(0, encR(0, 0, 0, 0, 21), 21, 0);
        emitRet(0, encR(0, 1, 0, 0, 22), 22, a);
        emit(0, encJ(0, 0));
        // Upper immediates and jumps
        emitRet(1, encU(LUI, iU, 1), 1, {iU, 12'b0});
        emitRet(1, encU(AUIPC, iU2, 2), 2, 32'd4 + {iU2, 12'b0});
        emitRet(1, encJ(3, 12), 3, 12);
        emit(1, encI(OP_IMM, 1, 0, 0, 4));
        emit(1, encI(OP_IMM, 2, 0, 0, 4));
        emitRet(1, encI(OP_IMM, 40, 0, 0, 5), 5, 40);
        emitRet(1, encI(JALR, 5, 5, 0, 6), 6, 28);
        repeat (4) emit(1, encI(OP_IMM, 3, 0, 0, 4));
        emitRet(1, encI(OP_IMM, 9, 0, 0, 7), 7, 9);
        emit(1, encJ(0, 0));
        // Each branch taken, then not taken
        emitRet(2, encI(OP_IMM, 12'hffd, 0, 0, 1), 1, 32'hffff_fffd);
        emitRet(2, encI(OP_IMM, 5, 0, 0, 2), 2, 5);
        for (int k = 0; k < 6; k++) begin
            emitRet(2, encB(f3s[k], tkA[k], tkB[k], 8), 0, 0);
            emit(2, encI(OP_IMM, 1, 0, 0, 9));
            emitRet(2, encB(f3s[k], ntA[k], ntB[k], 8), 0, 0);
            emitRet(2, encI(OP_IMM, k, 0, 0, 10 + k), 10 + k, k);
        end
        emit(2, encJ(0, 0));
        // Stores, loads and load-use under contention
        emitRet(3, encI(OP_IMM, iA, 0, 0, 1), 1, a);
        emitRet(3, encS(160, 1, 0), 0, 0);
        emitRet(3, encI(LOAD, 160, 0, 2, 2), 2, a);
        emitRet(3, encS(168, 2, 0), 0, 0);
        emitRet(3, encI(LOAD, 164, 0, 2, 3), 3, dA);
        emitRet(3, encI(LOAD, 172, 0, 2, 4), 4, dB);
        emitRet(3, encI(OP_IMM, 1, 4, 0, 5), 5, dB + 1);
        emitRet(3, encI(LOAD, 168, 0, 2, 6), 6, a);
        emitRet(3, encR(0, 5, 6, 0, 7), 7, a + dB + 1);
        emitRet(3, encI(LOAD, 164, 0, 2, 8), 8, dA);
        emitRet(3, encR(0, 7, 8, 4, 9), 9, dA ^ (a + dB + 1));
        emit(3, encJ(0, 0));
        prog[3][40] = '0;
        prog[3][41] = dA;
        prog[3][42] = '0;
        prog[3][43] = dB;
        nWords[3] = 44;
    endtask

    task automatic watchdog(int cycles);
        #(cycles * 100);
        $display("Retirement stalled before the expected trace completed");
        $display("test failed");
        $fatal(1, "watchdog expired");
    endtask

    always @(negedge clk) begin
        if (dut.props.failCount != 0) begin
            $display("A bound protocol assertion on the core failed");
            $display("test failed");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        int limit;
        int count;
        rstN     = 1'b0;
        run      = 1'b0;
        hostWr   = 1'b0;
        hostAddr = '0;
        hostData = '0;
        void'($urandom(64));
        for (int t = 0; t < NUM_TESTS; t++) begin
            nWords[t] = 0;
            nRet[t]   = 0;
            for (int i = 0; i < MAX_WORDS; i++) begin
                prog[t][i] = '0;
            end
        end
        buildTable();
        limit = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit += 20 * nRet[t] + 2 * nWords[t] + 14;
        end
        fork
            watchdog(limit);
        join_none
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(negedge clk);
            rstN = 1'b0;
            run  = 1'b0;
            repeat (10) @(negedge clk);
            rstN = 1'b1;
            for (int i = 0; i < nWords[t]; i++) begin
                @(negedge clk);
                hostWr   = 1'b1;
                hostAddr = memAddrT'(i);
                hostData = prog[t][i];
            end
            @(negedge clk);
            hostWr = 1'b0;
            run    = 1'b1;
            count  = 0;
            while (count < nRet[t]) begin
                @(negedge clk);
                if (retireValid) begin
                    checkPc("retire.pc", expPc[t][count], retire.pc);
                    checkReg("retire.rd", expRd[t][count], retire.rd);
                    checkWord("retire.data", expData[t][count], retire.data);
                    count++;
                end
            end
            run = 1'b0;
        end
        $display("test passed");
        $finish;
    end

endmodule

//--- bench/miniCore_properties.sv
`timescale 1ns/1ps

module miniCoreProperties (
    input logic           clk,
    input logic           rstN,
    input logic           run,
    input logic           hostWr,
    input logic           hostGnt,
    input logic           dataGnt,
    input logic           fetchGnt,
    input busPkg::memReqT dataReq,
    input busPkg::memReqT fetchReq,
    input busPkg::memRspT dataRsp,
    input busPkg::memRspT fetchRsp,
    input isaPkg::instrT  instr,
    input logic           retireValid,
    input busPkg::retireT retire
);

    import isaPkg::*;
    import busPkg::*;

    int   failCount = 0;
    logic writesNoReg;

    // Branches and stores leave the register file alone
    assign writesNoReg = (instr[6:0] == BRANCH) || (instr[6:0] == STORE);

    oneGrant: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({hostGnt, dataGnt, fetchGnt}))
        else begin
            failCount++;
            $error("more than one grant in a cycle");
        end

    // A granted read is answered next cycle at its own port only
    dataRspAfterRead: assert property (@(posedge clk) disable iff (!rstN)
        (dataGnt && !dataReq.write) |=> (dataRsp.valid && !fetchRsp.valid))
        else begin
            failCount++;
            $error("granted data read got no response on the data port");
        end

    fetchRspAfterRead: assert property (@(posedge clk) disable iff (!rstN)
        (fetchGnt && !fetchReq.write) |=> (fetchRsp.valid && !dataRsp.valid))
        else begin
            failCount++;
            $error("granted fetch read got no response on the fetch port");
        end

    rdZeroNoWrite: assert property (@(posedge clk) disable iff (!rstN)
        (retireValid && writesNoReg) |-> (retire.rd == '0))
        else begin
            failCount++;
            $error("retire reports rd for an instruction that writes nothing");
        end

    idleNoGrant: assert property (@(posedge clk) disable iff (!rstN)
        (!run && !hostWr) |-> !(hostGnt || dataGnt || fetchGnt))
        else begin
            failCount++;
            $error("grant while the core is idle");
        end

endmodule

bind miniCore miniCoreProperties props (
    .clk         (clk),
    .rstN        (rstN),
    .run         (run),
    .hostWr      (hostWr),
    .hostGnt     (hostGnt),
    .dataGnt     (dataGnt),
    .fetchGnt    (fetchGnt),
    .dataReq     (dataReq),
    .fetchReq    (fetchReq),
    .dataRsp     (dataRsp),
    .fetchRsp    (fetchRsp),
    .instr       (instr),
    .retireValid (retireValid),
    .retire      (retire)
);

//--- design/busPkg.sv
`include "core_settings.svh"

package busPkg;

    typedef logic [`MEM_ADDR_W-1:0] memAddrT;
    typedef logic [31:0]            pcT;

    typedef struct packed {
        logic         valid;
        logic         write;
        memAddrT      addr;
        isaPkg::wordT wdata;
    } memReqT;

    typedef struct packed {
        logic         valid;
        isaPkg::wordT rdata;
    } memRspT;

    // One committed instruction, rd is 0 when nothing was written
    typedef struct packed {
        pcT             pc;
        isaPkg::regIdxT rd;
        isaPkg::wordT   data;
    } retireT;

endpackage

//--- design/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  isaPkg::opcodeT op,
    input  logic [2:0]     funct3,
    input  logic           funct7b5,
    input  logic           flush,
    input  logic           stall,
    output isaPkg::ctrlT   ctrl
);

    import isaPkg::*;

    always_comb begin
        ctrl.immFmt    = IMM_I;
        ctrl.aluOp     = ADD;
        ctrl.aluSrcA   = 1'b0;
        ctrl.aluSrcB   = 1'b0;
        ctrl.resultSrc = RES_ALU;
        ctrl.regWrite  = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.memRead   = 1'b0;
        ctrl.branch    = 1'b0;
        ctrl.jump      = 1'b0;
        if (!flush) begin
            case (op)
                OP: begin
                    ctrl.regWrite = !stall;
                    case (funct3)
                        3'b000: ctrl.aluOp = funct7b5 ? SUB : ADD;
                        3'b001: ctrl.aluOp = SLL;
                        3'b010: ctrl.aluOp = SLT;
                        3'b011: ctrl.aluOp = SLTU;
                        3'b100: ctrl.aluOp = XOR;
                        3'b101: ctrl.aluOp = funct7b5 ? SRA : SRL;
                        3'b110: ctrl.aluOp = OR;
                        default: ctrl.aluOp = AND;
                    endcase
                end
                OP_IMM: begin
                    ctrl.regWrite = !stall;
                    ctrl.aluSrcB  = 1'b1;
                    case (funct3)
                        3'b000: ctrl.aluOp = ADD;
                        3'b001: begin
                            ctrl.aluOp  = SLL;
                            ctrl.immFmt = IMM_SHAMT;
                        end
                        3'b010: ctrl.aluOp = SLT;
                        3'b011: ctrl.aluOp = SLTU;
                        3'b100: ctrl.aluOp = XOR;
                        // SRAI shares the SRA code
                        3'b101: begin
                            ctrl.aluOp  = funct7b5 ? SRA : SRL;
                            ctrl.immFmt = IMM_SHAMT;
                        end
                        3'b110: ctrl.aluOp = OR;
                        default: ctrl.aluOp = AND;
                    endcase
                end
                LOAD: begin
                    ctrl.regWrite  = !stall;
                    ctrl.memRead   = 1'b1;
                    ctrl.aluSrcB   = 1'b1;
                    ctrl.resultSrc = RES_MEM;
                end
                STORE: begin
                    ctrl.memWrite = !stall;
                    ctrl.aluSrcB  = 1'b1;
                    ctrl.immFmt   = IMM_S;
                end
                LUI: begin
                    ctrl.regWrite = !stall;
                    ctrl.aluOp    = PASSB;
                    ctrl.aluSrcB  = 1'b1;
                    ctrl.immFmt   = IMM_U;
                end
                AUIPC: begin
                    ctrl.regWrite = !stall;
                    ctrl.aluSrcA  = 1'b1;
                    ctrl.aluSrcB  = 1'b1;
                    ctrl.immFmt   = IMM_U;
                end
                // ALU forms the jump target, rd gets pc+4
                JAL: begin
                    ctrl.regWrite  = !stall;
                    ctrl.jump      = !stall;
                    ctrl.aluSrcA   = 1'b1;
                    ctrl.aluSrcB   = 1'b1;
                    ctrl.immFmt    = IMM_J;
                    ctrl.resultSrc = RES_PC4;
                end
                JALR: begin
                    ctrl.regWrite  = !stall;
                    ctrl.jump      = !stall;
                    ctrl.aluSrcB   = 1'b1;
                    ctrl.resultSrc = RES_PC4;
                end
                BRANCH: begin
                    ctrl.branch  = 1'b1;
                    ctrl.aluSrcA = 1'b1;
                    ctrl.aluSrcB = 1'b1;
                    ctrl.immFmt  = IMM_B;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- design/executeUnit.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module executeUnit (
    input  logic           clk,
    input  logic           rstN,
    input  logic           instrValid,
    input  isaPkg::instrT  instr,
    input  busPkg::pcT     instrPc,
    input  logic           flush,
    output busPkg::memReqT memReq,
    input  logic           memGnt,
    input  busPkg::memRspT memRsp,
    output logic           stall,
    output logic           redirect,
    output busPkg::pcT     redirectPc,
    output logic           retireValid,
    output busPkg::retireT retire
);

    import isaPkg::*;
    import busPkg::*;

    typedef enum logic {IDLE, WAIT_LOAD} stateT;

    stateT  state;
    ctrlT   ctrl;
    logic   ctrlStall;
    regIdxT rs1;
    regIdxT rs2;
    regIdxT rd;
    wordT   regs [32];
    wordT   rs1Val;
    wordT   rs2Val;
    wordT   imm;
    wordT   srcA;
    wordT   srcB;
    wordT   aluResult;
    wordT   wbData;
    pcT     pcPlus4;
    logic   takeBranch;
    logic   regWe;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // Commit controls stay off until the load data is back
    assign ctrlStall = (state == WAIT_LOAD) && !memRsp.valid;

    controlUnit uCtrl (
        .op       (opcodeT'(instr[6:0])),
        .funct3   (instr[14:12]),
        .funct7b5 (instr[30]),
        .flush    (flush),
        .stall    (ctrlStall),
        .ctrl     (ctrl)
    );

    assign rs1Val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Val = (rs2 == '0) ? '0 : regs[rs2];

    always_comb begin
        case (ctrl.immFmt)
            IMM_SHAMT: imm = {27'b0, instr[24:20]};
            IMM_S:     imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:     imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};
            IMM_U:     imm = {instr[31:12], 12'b0};
            IMM_J:     imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                              instr[30:21], 1'b0};
            default:   imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    assign srcA = ctrl.aluSrcA ? instrPc : rs1Val;
    assign srcB = ctrl.aluSrcB ? imm : rs2Val;

    always_comb begin
        case (ctrl.aluOp)
            SUB:     aluResult = srcA - srcB;
            AND:     aluResult = srcA & srcB;
            OR:      aluResult = srcA | srcB;
            XOR:     aluResult = srcA ^ srcB;
            SLL:     aluResult = srcA << srcB[4:0];
            SRL:     aluResult = srcA >> srcB[4:0];
            SRA:     aluResult = $signed(srcA) >>> srcB[4:0];
            SLT:     aluResult = {31'b0, $signed(srcA) < $signed(srcB)};
            SLTU:    aluResult = {31'b0, srcA < srcB};
            PASSB:   aluResult = srcB;
            default: aluResult = srcA + srcB;
        endcase
    end

    always_comb begin
        case (instr[14:12])
            3'b000:  takeBranch = rs1Val == rs2Val;
            3'b001:  takeBranch = rs1Val != rs2Val;
            3'b100:  takeBranch = $signed(rs1Val) < $signed(rs2Val);
            3'b101:  takeBranch = $signed(rs1Val) >= $signed(rs2Val);
            3'b110:  takeBranch = rs1Val < rs2Val;
            3'b111:  takeBranch = rs1Val >= rs2Val;
            default: takeBranch = 1'b0;
        endcase
    end

    assign pcPlus4 = instrPc + 32'd4;

    always_comb begin
        case (ctrl.resultSrc)
            RES_MEM: wbData = memRsp.rdata;
            RES_PC4: wbData = pcPlus4;
            default: wbData = aluResult;
        endcase
    end

    // Target from the ALU, bit 0 dropped for JALR
    assign redirect   = instrValid && (ctrl.jump || (ctrl.branch && takeBranch));
    assign redirectPc = {aluResult[31:1], 1'b0};

    assign memReq.valid = instrValid && (state == IDLE) && (ctrl.memRead || ctrl.memWrite);
    assign memReq.write = ctrl.memWrite;
    assign memReq.addr  = aluResult[`MEM_ADDR_W+1:2];
    assign memReq.wdata = rs2Val;

    always_comb begin
        if (!instrValid) begin
            stall = 1'b0;
        end else if (state == WAIT_LOAD) begin
            stall = !memRsp.valid;
        end else if (ctrl.memRead) begin
            stall = 1'b1;
        end else begin
            stall = ctrl.memWrite && !memGnt;
        end
    end

    assign retireValid = instrValid && !stall;
    assign retire.pc   = instrPc;
    assign retire.rd   = ctrl.regWrite ? rd : '0;
    assign retire.data = ctrl.regWrite ? wbData : '0;

    assign regWe = retireValid && ctrl.regWrite && (rd != '0);

    always_ff @(posedge clk) begin
        if (regWe) begin
            regs[rd] <= wbData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (memReq.valid && !memReq.write && memGnt) begin
                        state <= WAIT_LOAD;
                    end
                end
                WAIT_LOAD: begin
                    if (memRsp.valid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- design/fetchUnit.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module fetchUnit (
    input  logic           clk,
    input  logic           rstN,
    input  logic           run,
    input  logic           stall,
    input  logic           redirect,
    input  busPkg::pcT     redirectPc,
    output busPkg::memReqT memReq,
    input  logic           memGnt,
    input  busPkg::memRspT memRsp,
    output logic           instrValid,
    output isaPkg::instrT  instr,
    output busPkg::pcT     instrPc,
    output logic           flush
);

    import isaPkg::*;
    import busPkg::*;

    pcT    pc;
    pcT    pendPc;
    logic  pendFlush;
    logic  holdValid;
    instrT holdInstr;
    pcT    holdPc;

    assign memReq.valid = run && !stall;
    assign memReq.write = 1'b0;
    assign memReq.addr  = pc[`MEM_ADDR_W+1:2];
    assign memReq.wdata = '0;

    // Wrong-path word returning after a redirect
    assign flush = pendFlush;

    always_comb begin
        if (holdValid) begin
            instrValid = 1'b1;
            instr      = holdInstr;
            instrPc    = holdPc;
        end else begin
            instrValid = memRsp.valid && !pendFlush;
            instr      = memRsp.rdata;
            instrPc    = pendPc;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc        <= `RESET_PC;
            pendFlush <= 1'b0;
            holdValid <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= redirectPc;
            end else if (memGnt) begin
                pc <= pc + 32'd4;
            end
            pendFlush <= redirect && memGnt;
            holdValid <= stall && instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (memGnt) begin
            pendPc <= pc;
        end
        // Present the same instruction again next cycle
        if (stall) begin
            holdInstr <= instr;
            holdPc    <= instrPc;
        end
    end

endmodule

//--- design/isaPkg.sv
package isaPkg;

    typedef logic [31:0] wordT;
    typedef logic [31:0] instrT;
    typedef logic [4:0]  regIdxT;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011
    } opcodeT;

    // Codes 8 and 12..15 unused
    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        AND   = 4'd2,
        OR    = 4'd3,
        XOR   = 4'd4,
        SLL   = 4'd5,
        SRL   = 4'd6,
        SRA   = 4'd7,
        SLT   = 4'd9,
        SLTU  = 4'd10,
        PASSB = 4'd11
    } aluOpT;

    typedef enum logic [2:0] {IMM_I, IMM_SHAMT, IMM_S, IMM_B, IMM_U, IMM_J} immFmtT;

    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} resultSrcT;

    typedef struct packed {
        immFmtT    immFmt;
        aluOpT     aluOp;
        logic      aluSrcA;    // PC in place of rs1
        logic      aluSrcB;    // immediate in place of rs2
        resultSrcT resultSrc;
        logic      regWrite;
        logic      memWrite;
        logic      memRead;
        logic      branch;
        logic      jump;
    } ctrlT;

endpackage

//--- design/memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
    input  logic           clk,
    input  logic           rstN,
    input  busPkg::memReqT hostReq,
    input  busPkg::memReqT dataReq,
    input  busPkg::memReqT fetchReq,
    output logic           hostGnt,
    output logic           dataGnt,
    output logic           fetchGnt,
    output busPkg::memReqT memReq,
    input  busPkg::memRspT memRsp,
    output busPkg::memRspT dataRsp,
    output busPkg::memRspT fetchRsp
);

    logic rspToData;
    logic rspToFetch;

    // Host first, then data, then fetch
    assign hostGnt  = hostReq.valid;
    assign dataGnt  = dataReq.valid && !hostReq.valid;
    assign fetchGnt = fetchReq.valid && !hostReq.valid && !dataReq.valid;

    assign memReq = hostGnt ? hostReq : (dataGnt ? dataReq : fetchReq);

    // Owner of the read that returns next cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rspToData  <= 1'b0;
            rspToFetch <= 1'b0;
        end else begin
            rspToData  <= dataGnt && !dataReq.write;
            rspToFetch <= fetchGnt && !fetchReq.write;
        end
    end

    assign dataRsp.valid  = memRsp.valid && rspToData;
    assign dataRsp.rdata  = memRsp.rdata;
    assign fetchRsp.valid = memRsp.valid && rspToFetch;
    assign fetchRsp.rdata = memRsp.rdata;

endmodule

//--- design/miniCore.sv
`timescale 1ns/1ps

module miniCore (
    input  logic            clk,
    input  logic            rstN,
    input  logic            run,
    input  logic            hostWr,
    input  busPkg::memAddrT hostAddr,
    input  isaPkg::wordT    hostData,
    output logic            retireValid,
    output busPkg::retireT  retire
);

    import isaPkg::*;
    import busPkg::*;

    memReqT hostReq;
    memReqT dataReq;
    memReqT fetchReq;
    memReqT memReq;
    memRspT memRsp;
    memRspT dataRsp;
    memRspT fetchRsp;
    logic   hostGnt;
    logic   dataGnt;
    logic   fetchGnt;
    logic   instrValid;
    instrT  instr;
    pcT     instrPc;
    logic   flush;
    logic   stall;
    logic   redirect;
    pcT     redirectPc;

    // Host port only ever writes
    assign hostReq.valid = hostWr;
    assign hostReq.write = 1'b1;
    assign hostReq.addr  = hostAddr;
    assign hostReq.wdata = hostData;

    fetchUnit uFetch (
        .clk        (clk),
        .rstN       (rstN),
        .run        (run),
        .stall      (stall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .memReq     (fetchReq),
        .memGnt     (fetchGnt),
        .memRsp     (fetchRsp),
        .instrValid (instrValid),
        .instr      (instr),
        .instrPc    (instrPc),
        .flush      (flush)
    );

    executeUnit uExec (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .instrPc     (instrPc),
        .flush       (flush),
        .memReq      (dataReq),
        .memGnt      (dataGnt),
        .memRsp      (dataRsp),
        .stall       (stall),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .retireValid (retireValid),
        .retire      (retire)
    );

    memArbiter uArb (
        .clk      (clk),
        .rstN     (rstN),
        .hostReq  (hostReq),
        .dataReq  (dataReq),
        .fetchReq (fetchReq),
        .hostGnt  (hostGnt),
        .dataGnt  (dataGnt),
        .fetchGnt (fetchGnt),
        .memReq   (memReq),
        .memRsp   (memRsp),
        .dataRsp  (dataRsp),
        .fetchRsp (fetchRsp)
    );

    unifiedMem uMem (
        .clk (clk),
        .req (memReq),
        .rsp (memRsp)
    );

endmodule

//--- design/unifiedMem.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module unifiedMem (
    input  logic           clk,
    input  busPkg::memReqT req,
    output busPkg::memRspT rsp
);

    import isaPkg::*;

    wordT mem [`MEM_WORDS];

    always_ff @(posedge clk) begin
        if (req.valid && req.write) begin
            mem[req.addr] <= req.wdata;
        end
    end

    // Read data lands one cycle after the request
    // Writes raise no response
    always_ff @(posedge clk) begin
        rsp.valid <= req.valid && !req.write;
        rsp.rdata <= mem[req.addr];
    end

endmodule

//--- include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Unified memory geometry, in 32-bit words
`define MEM_ADDR_W 8
`define MEM_WORDS  256

// Byte address of the first fetch
`define RESET_PC   32'h0000_0000

`endif

//--- sim.f
+incdir+include
design/isaPkg.sv
design/busPkg.sv
design/controlUnit.sv
design/fetchUnit.sv
design/executeUnit.sv
design/memArbiter.sv
design/unifiedMem.sv
design/miniCore.sv
bench/miniCore_properties.sv
bench/miniCoreTb.sv
